// File: bench/dog_anim_chk.sv
`default_nettype none

module dog_anim_chk (
    input wire                     ANIM_Clk,
    input wire                     Reset,
    input wire                     run,
    input wire scene_pkg::coord_t  dog_y,
    input wire anim_pkg::frame_e   frame,
    input wire                     jumping
);

    // the jump flag marks only the falling half
    jump_is_fall: assert property (@(posedge ANIM_Clk) disable iff (Reset)
        jumping |-> frame == anim_pkg::Fall)
        else $error("jumping is high while frame is not Fall");

    // a standing dog stays standing until run is seen
    stand_holds: assert property (@(posedge ANIM_Clk) disable iff (Reset)
        (frame == anim_pkg::Stand && !run) |=> frame == anim_pkg::Stand)
        else $error("frame left Stand while run was low");

    // off the arc the dog is on the ground or behind the grass
    row_on_ground: assert property (@(posedge ANIM_Clk) disable iff (Reset)
        !(frame inside {anim_pkg::Leap, anim_pkg::Fall})
            |-> (dog_y == scene_pkg::GROUND_Y || dog_y == scene_pkg::HIDDEN_Y))
        else $error("dog_y is off the ground and hidden rows outside a jump");

endmodule

bind dog_anim_top dog_anim_chk chk (
    .ANIM_Clk (ANIM_Clk),
    .Reset    (Reset),
    .run      (run),
    .dog_y    (dog_y),
    .frame    (frame),
    .jumping  (jumping)
);

`default_nettype wire

// File: bench/dog_anim_tb.sv
`default_nettype none

module dog_anim_tb;

    localparam int SURPRISE_TICKS = 2;
    localparam int MAX_LAP        = 8;
    localparam int RESET_CYCLES   = 16;
    localparam int NUM_ROWS       = 5;
    localparam int ROW_LIMIT      = 200;
    localparam int ARC_STEPS      = 10;

    logic               ANIM_Clk = 1'b0;
    logic               Reset;
    logic               run;
    logic               cfg_we;
    anim_pkg::cfg_reg_e cfg_sel;
    scene_pkg::coord_t  cfg_data;
    scene_pkg::coord_t  dog_x;
    scene_pkg::coord_t  dog_y;
    anim_pkg::frame_e   frame;
    logic               jumping;

    // one row per scenario: name, start column, lap step, sniff laps, ticks from run to Idle
    string row_name    [NUM_ROWS] = '{"default", "moved", "swapped", "lap_zero", "rerun_default"};
    int    row_start   [NUM_ROWS] = '{11, 40, 100, 0, 11};
    int    row_step    [NUM_ROWS] = '{32, 20, 12, 40, 32};
    int    row_sniff_a [NUM_ROWS] = '{4, 2, 6, 0, 4};
    int    row_sniff_b [NUM_ROWS] = '{7, 5, 1, 3, 7};
    int    row_ticks   [NUM_ROWS] = '{68, 60, 64, 52, 68};

    // jump arc points
    int rise_x [ARC_STEPS] = '{267, 276, 285, 294, 303, 312, 321, 330, 341, 352};
    int rise_y [ARC_STEPS] = '{290, 274, 260, 248, 238, 229, 222, 217, 213, 212};
    int fall_x [ARC_STEPS] = '{352, 363, 374, 383, 392, 401, 410, 419, 428, 437};
    int fall_y [ARC_STEPS] = '{212, 213, 217, 222, 229, 238, 248, 260, 274, 290};

    // reference model of the dog
    anim_pkg::dog_state_e m_state;
    int m_lap;
    int m_pairs;
    int m_stops;
    int m_surp;
    int m_arc;
    int m_start;
    int m_step;
    int m_sniff_a;
    int m_sniff_b;

    string cur_name;
    int    value_errors = 0;
    int    other_errors = 0;

    dog_anim_top #(
        .SURPRISE_TICKS (SURPRISE_TICKS),
        .MAX_LAP        (MAX_LAP)
    ) dut (
        .ANIM_Clk (ANIM_Clk),
        .Reset    (Reset),
        .run      (run),
        .cfg_we   (cfg_we),
        .cfg_sel  (cfg_sel),
        .cfg_data (cfg_data),
        .dog_x    (dog_x),
        .dog_y    (dog_y),
        .frame    (frame),
        .jumping  (jumping)
    );

    always #2 ANIM_Clk = ~ANIM_Clk;

    task automatic model_reset();
        m_state   = anim_pkg::Idle;
        m_lap     = 0;
        m_pairs   = 0;
        m_stops   = 0;
        m_surp    = 0;
        m_arc     = 0;
        m_start   = 11;
        m_step    = 32;
        m_sniff_a = 4;
        m_sniff_b = 7;
    endtask

    // one animation tick of the sequence rules, using the inputs seen at the edge
    task automatic model_step();
        logic sniff;
        case (m_state)
            anim_pkg::Idle:
                if (run)
                    m_state = anim_pkg::Walk1;
            anim_pkg::Walk1: m_state = anim_pkg::Walk2;
            anim_pkg::Walk2: m_state = anim_pkg::Walk3;
            anim_pkg::Walk3: m_state = anim_pkg::Walk4;
            anim_pkg::Walk4:
            begin
                sniff = (m_lap == m_sniff_a) || (m_lap == m_sniff_b);
                m_lap = (m_lap == MAX_LAP) ? 0 : m_lap + 1;
                m_state = sniff ? anim_pkg::Sniff1 : anim_pkg::Walk1;
            end
            anim_pkg::Sniff1: m_state = anim_pkg::Sniff2;
            anim_pkg::Sniff2:
            begin
                m_pairs++;
                if (m_pairs < 3)
                    m_state = anim_pkg::Sniff1;
                else
                begin
                    m_pairs = 0;
                    m_stops++;
                    m_state = (m_stops == 2) ? anim_pkg::Surprised : anim_pkg::Walk1;
                end
            end
            anim_pkg::Surprised:
            begin
                m_surp++;
                if (m_surp == SURPRISE_TICKS)
                begin
                    m_surp = 0;
                    m_state = anim_pkg::JumpRise;
                end
            end
            anim_pkg::JumpRise, anim_pkg::JumpFall:
            begin
                if (m_arc == ARC_STEPS - 1)
                begin
                    m_arc = 0;
                    m_state = (m_state == anim_pkg::JumpRise) ? anim_pkg::JumpFall
                                                              : anim_pkg::Hidden;
                end
                else
                    m_arc++;
            end
            anim_pkg::Hidden:
            begin
                m_lap = 0;
                m_stops = 0;
                m_state = anim_pkg::Idle;
            end
            default: m_state = anim_pkg::Idle;
        endcase
        if (cfg_we)
        begin
            case (cfg_sel)
                anim_pkg::CfgStartX: m_start = int'(cfg_data);
                anim_pkg::CfgStep:   m_step = int'(cfg_data);
                anim_pkg::CfgSniffA: m_sniff_a = int'(cfg_data[3:0]);
                default:             m_sniff_b = int'(cfg_data[3:0]);
            endcase
        end
    endtask

    function automatic int frame_for(anim_pkg::dog_state_e s);
        case (s)
            anim_pkg::Walk1:     return int'(anim_pkg::Stride1);
            anim_pkg::Walk2:     return int'(anim_pkg::Stride2);
            anim_pkg::Walk3:     return int'(anim_pkg::Stride3);
            anim_pkg::Walk4:     return int'(anim_pkg::Stride3);
            anim_pkg::Sniff1:    return int'(anim_pkg::SniffDown);
            anim_pkg::Sniff2:    return int'(anim_pkg::SniffUp);
            anim_pkg::Surprised: return int'(anim_pkg::Startled);
            anim_pkg::JumpRise:  return int'(anim_pkg::Leap);
            anim_pkg::JumpFall:  return int'(anim_pkg::Fall);
            default:             return int'(anim_pkg::Stand);
        endcase
    endfunction

    task automatic check_value(input string what, input int expected, input int actual);
        assert (expected == actual)
        else
        begin
            value_errors++;
            $display("FAIL %s %s: expected %0d, actual %0d", cur_name, what, expected, actual);
        end
    endtask

    task automatic compare_outputs();
        int k;
        int ex;
        int ey;
        case (m_state)
            anim_pkg::Walk1: k = 1;
            anim_pkg::Walk2: k = 2;
            anim_pkg::Walk3: k = 3;
            default:         k = 4;
        endcase
        ex = m_start + int'(scene_pkg::STRIDE_X) * k + m_step * m_lap;
        ey = int'(scene_pkg::GROUND_Y);
        if (m_state == anim_pkg::Idle)
            ex = m_start;
        else if (m_state == anim_pkg::Hidden)
            ey = int'(scene_pkg::HIDDEN_Y);
        else if (m_state == anim_pkg::JumpRise)
        begin
            ex = rise_x[m_arc];
            ey = rise_y[m_arc];
        end
        else if (m_state == anim_pkg::JumpFall)
        begin
            ex = fall_x[m_arc];
            ey = fall_y[m_arc];
        end
        check_value("dog_x", ex % 1024, int'(dog_x));
        check_value("dog_y", ey, int'(dog_y));
        check_value("frame", frame_for(m_state), int'(frame));
        check_value("jumping", int'(m_state == anim_pkg::JumpFall), int'(jumping));
    endtask

    // outputs settle after the rising edge and are checked at the falling one
    task automatic tick();
        @(posedge ANIM_Clk);
        model_step();
        @(negedge ANIM_Clk);
        compare_outputs();
    endtask

    task automatic write_config(input anim_pkg::cfg_reg_e sel, input int value);
        cfg_we   = 1'b1;
        cfg_sel  = sel;
        cfg_data = scene_pkg::coord_t'(value);
        tick();
        cfg_we   = 1'b0;
    endtask

    function automatic logic dut_idle();
        return (frame == anim_pkg::Stand) && (dog_y == scene_pkg::GROUND_Y);
    endfunction

    task automatic finish_run();
        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    endtask

    initial
    begin
        int count;
        Reset    = 1'b1;
        run      = 1'b0;
        cfg_we   = 1'b0;
        cfg_sel  = anim_pkg::CfgStartX;
        cfg_data = '0;
        model_reset();
        repeat (RESET_CYCLES) @(negedge ANIM_Clk);
        Reset = 1'b0;
        cur_name = "after_reset";
        compare_outputs();
        // run stays low, so the dog must stand still
        repeat (8) tick();
        for (int r = 0; r < NUM_ROWS; r++)
        begin
            cur_name = row_name[r];
            write_config(anim_pkg::CfgStartX, row_start[r]);
            write_config(anim_pkg::CfgStep, row_step[r]);
            write_config(anim_pkg::CfgSniffA, row_sniff_a[r]);
            write_config(anim_pkg::CfgSniffB, row_sniff_b[r]);
            run = 1'b1;
            tick();
            run = 1'b0;
            count = 1;
            while (!dut_idle() && count < ROW_LIMIT)
            begin
                tick();
                count++;
            end
            assert (count < ROW_LIMIT)
            else
            begin
                other_errors++;
                $display("%s: the dog never returned to Idle", cur_name);
            end
            check_value("ticks to Idle", row_ticks[r], count);
            repeat (3) tick();
        end
        finish_run();
    end

    // watchdog
    initial
    begin
        repeat (RESET_CYCLES + NUM_ROWS * ROW_LIMIT) @(posedge ANIM_Clk);
        other_errors++;
        $display("watchdog timeout: the run did not finish in %0d ticks", NUM_ROWS * ROW_LIMIT);
        finish_run();
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the dog animation testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module dog_anim_tb -f sources.f -o dog_anim_sim

./obj_dir/dog_anim_sim | tee sim.log

if grep -q "^Simulation passed$" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

// File: source/anim_pkg.sv
`default_nettype none

package anim_pkg;

    // counter widths
    localparam int LAP_W = 4;
    localparam int ARC_W = 4;

    // the jump table has this many points per half
    localparam int ARC_STEPS = 10;

    typedef logic [LAP_W-1:0] lap_t;
    typedef logic [ARC_W-1:0] arc_idx_t;

    // dog behavior states, one per animation tick
    typedef enum logic [4:0] {
        Idle,
        Walk1,
        Walk2,
        Walk3,
        Walk4,
        Sniff1,
        Sniff2,
        Surprised,
        JumpRise,
        JumpFall,
        Hidden
    } dog_state_e;

    // sprite frame codes seen by the renderer
    typedef enum logic [4:0] {
        Stand     = 5'd0,
        Stride1   = 5'd1,
        Stride2   = 5'd2,
        Stride3   = 5'd3,
        SniffDown = 5'd4,
        SniffUp   = 5'd5,
        Startled  = 5'd6,
        Leap      = 5'd7,
        Fall      = 5'd8
    } frame_e;

    // configuration register select
    typedef enum logic [1:0] {
        CfgStartX,
        CfgStep,
        CfgSniffA,
        CfgSniffB
    } cfg_reg_e;

endpackage

`default_nettype wire

// File: source/dog_anim_top.sv
`default_nettype none

module dog_anim_top #(
    parameter int SURPRISE_TICKS = 2,
    parameter int MAX_LAP        = 8
) (
    input  wire                     ANIM_Clk,
    input  wire                     Reset,
    input  wire                     run,
    input  wire                     cfg_we,
    input  wire anim_pkg::cfg_reg_e cfg_sel,
    input  wire scene_pkg::coord_t  cfg_data,
    output scene_pkg::coord_t       dog_x,
    output scene_pkg::coord_t       dog_y,
    output anim_pkg::frame_e        frame,
    output logic                    jumping
);

    dog_pose_if pose ();

    anim_pkg::lap_t sniff_lap_a;
    anim_pkg::lap_t sniff_lap_b;

    dog_config u_config (
        .ANIM_Clk    (ANIM_Clk),
        .Reset       (Reset),
        .cfg_we      (cfg_we),
        .cfg_sel     (cfg_sel),
        .cfg_data    (cfg_data),
        .pose        (pose.cfg),
        .sniff_lap_a (sniff_lap_a),
        .sniff_lap_b (sniff_lap_b)
    );

    dog_sequencer #(
        .SURPRISE_TICKS (SURPRISE_TICKS),
        .MAX_LAP        (MAX_LAP)
    ) u_sequencer (
        .ANIM_Clk    (ANIM_Clk),
        .Reset       (Reset),
        .run         (run),
        .sniff_lap_a (sniff_lap_a),
        .sniff_lap_b (sniff_lap_b),
        .pose        (pose.sequencer)
    );

    dog_position u_position (
        .pose    (pose.position),
        .dog_x   (dog_x),
        .dog_y   (dog_y),
        .frame   (frame),
        .jumping (jumping)
    );

endmodule

`default_nettype wire

// File: source/dog_config.sv
`default_nettype none

module dog_config (
    input  wire                 ANIM_Clk,
    input  wire                 Reset,
    input  wire                 cfg_we,
    input  wire anim_pkg::cfg_reg_e cfg_sel,
    input  wire scene_pkg::coord_t  cfg_data,
    dog_pose_if.cfg             pose,
    output anim_pkg::lap_t      sniff_lap_a,
    output anim_pkg::lap_t      sniff_lap_b
);

    scene_pkg::coord_t start_x_q;
    scene_pkg::coord_t step_x_q;

    // one register per select code, written on the strobe
    always_ff @(posedge ANIM_Clk or posedge Reset)
    begin
        if (Reset)
        begin
            start_x_q   <= scene_pkg::DEFAULT_START_X;
            step_x_q    <= scene_pkg::DEFAULT_STEP_X;
            sniff_lap_a <= scene_pkg::DEFAULT_SNIFF_A;
            sniff_lap_b <= scene_pkg::DEFAULT_SNIFF_B;
        end
        else if (cfg_we)
        begin
            unique case (cfg_sel)
                anim_pkg::CfgStartX: start_x_q <= cfg_data;
                anim_pkg::CfgStep:   step_x_q  <= cfg_data;
                // sniff laps only need the low bits
                anim_pkg::CfgSniffA: sniff_lap_a <= cfg_data[anim_pkg::LAP_W-1:0];
                anim_pkg::CfgSniffB: sniff_lap_b <= cfg_data[anim_pkg::LAP_W-1:0];
            endcase
        end
    end

    assign pose.start_x = start_x_q;
    assign pose.step_x  = step_x_q;

endmodule

`default_nettype wire

// File: source/dog_pose_if.sv
`default_nettype none

// everything the position unit needs to place the dog
interface dog_pose_if;

    anim_pkg::dog_state_e state;
    anim_pkg::lap_t       walk_lap;
    anim_pkg::arc_idx_t   arc_idx;
    scene_pkg::coord_t    start_x;
    scene_pkg::coord_t    step_x;

    modport sequencer (output state, output walk_lap, output arc_idx);

    modport cfg (output start_x, output step_x);

    modport position (
        input state,
        input walk_lap,
        input arc_idx,
        input start_x,
        input step_x
    );

endinterface

`default_nettype wire

// File: source/dog_position.sv
`default_nettype none

module dog_position (
    dog_pose_if.position       pose,
    output scene_pkg::coord_t  dog_x,
    output scene_pkg::coord_t  dog_y,
    output anim_pkg::frame_e   frame,
    output logic               jumping
);

    scene_pkg::coord_t lap_x;
    scene_pkg::coord_t arc_x;
    scene_pkg::coord_t arc_y;
    logic              falling;

    // column at the start of the current lap
    assign lap_x = pose.start_x
                 + scene_pkg::coord_t'(pose.step_x * scene_pkg::coord_t'(pose.walk_lap));

    assign falling = (pose.state == anim_pkg::JumpFall);

    jump_arc_rom u_arc (
        .falling (falling),
        .arc_idx (pose.arc_idx),
        .arc_x   (arc_x),
        .arc_y   (arc_y)
    );

    always_comb
    begin
        dog_x = lap_x + scene_pkg::coord_t'(4 * scene_pkg::STRIDE_X);
        dog_y = scene_pkg::GROUND_Y;
        frame = anim_pkg::Stand;
        unique case (pose.state)
            anim_pkg::Idle:
                dog_x = pose.start_x;
            anim_pkg::Walk1:
            begin
                dog_x = lap_x + scene_pkg::STRIDE_X;
                frame = anim_pkg::Stride1;
            end
            anim_pkg::Walk2:
            begin
                dog_x = lap_x + scene_pkg::coord_t'(2 * scene_pkg::STRIDE_X);
                frame = anim_pkg::Stride2;
            end
            anim_pkg::Walk3:
            begin
                dog_x = lap_x + scene_pkg::coord_t'(3 * scene_pkg::STRIDE_X);
                frame = anim_pkg::Stride3;
            end
            // last pose reuses the third stride sprite
            anim_pkg::Walk4:  frame = anim_pkg::Stride3;
            anim_pkg::Sniff1: frame = anim_pkg::SniffDown;
            anim_pkg::Sniff2: frame = anim_pkg::SniffUp;
            anim_pkg::Surprised: frame = anim_pkg::Startled;
            anim_pkg::JumpRise, anim_pkg::JumpFall:
            begin
                dog_x = arc_x;
                dog_y = arc_y;
                frame = falling ? anim_pkg::Fall : anim_pkg::Leap;
            end
            anim_pkg::Hidden: dog_y = scene_pkg::HIDDEN_Y;
            default: frame = anim_pkg::Stand;
        endcase
    end

    // only the downward half is flagged
    assign jumping = falling;

endmodule

`default_nettype wire

// File: source/dog_sequencer.sv
`default_nettype none

module dog_sequencer #(
    parameter int SURPRISE_TICKS = 2,
    parameter int MAX_LAP        = 8
) (
    input  wire                  ANIM_Clk,
    input  wire                  Reset,
    input  wire                  run,
    input  wire anim_pkg::lap_t  sniff_lap_a,
    input  wire anim_pkg::lap_t  sniff_lap_b,
    dog_pose_if.sequencer        pose
);

    localparam int SURP_W = (SURPRISE_TICKS > 1) ? $clog2(SURPRISE_TICKS) : 1;

    localparam anim_pkg::arc_idx_t ARC_LAST = anim_pkg::arc_idx_t'(anim_pkg::ARC_STEPS - 1);
    localparam anim_pkg::lap_t     LAP_LAST = anim_pkg::lap_t'(MAX_LAP);
    localparam logic [SURP_W-1:0]  SURP_LAST = SURP_W'(SURPRISE_TICKS - 1);

    anim_pkg::dog_state_e state;
    anim_pkg::dog_state_e next_state;
    anim_pkg::lap_t       walk_lap;
    anim_pkg::arc_idx_t   arc_idx;

    // sniff pairs within one stop, and stops taken so far
    logic [1:0]        sniff_cnt;
    logic              stop_cnt;
    logic [SURP_W-1:0] surp_cnt;

    logic sniff_here;
    logic stop_done;

    // the lap value before the increment picks the sniff points
    assign sniff_here = (walk_lap == sniff_lap_a) || (walk_lap == sniff_lap_b);
    assign stop_done  = (sniff_cnt == 2'd2);

    always_comb
    begin
        next_state = state;
        unique case (state)
            anim_pkg::Idle:
                if (run)
                    next_state = anim_pkg::Walk1;
            anim_pkg::Walk1: next_state = anim_pkg::Walk2;
            anim_pkg::Walk2: next_state = anim_pkg::Walk3;
            anim_pkg::Walk3: next_state = anim_pkg::Walk4;
            anim_pkg::Walk4:
                next_state = sniff_here ? anim_pkg::Sniff1 : anim_pkg::Walk1;
            anim_pkg::Sniff1: next_state = anim_pkg::Sniff2;
            anim_pkg::Sniff2:
                if (!stop_done)
                    next_state = anim_pkg::Sniff1;
                else if (stop_cnt)
                    next_state = anim_pkg::Surprised;
                else
                    next_state = anim_pkg::Walk1;
            anim_pkg::Surprised:
                if (surp_cnt == SURP_LAST)
                    next_state = anim_pkg::JumpRise;
            anim_pkg::JumpRise:
                if (arc_idx == ARC_LAST)
                    next_state = anim_pkg::JumpFall;
            anim_pkg::JumpFall:
                if (arc_idx == ARC_LAST)
                    next_state = anim_pkg::Hidden;
            anim_pkg::Hidden: next_state = anim_pkg::Idle;
            default: next_state = anim_pkg::Idle;
        endcase
    end

    always_ff @(posedge ANIM_Clk or posedge Reset)
    begin
        if (Reset)
        begin
            state     <= anim_pkg::Idle;
            walk_lap  <= '0;
            arc_idx   <= '0;
            sniff_cnt <= '0;
            stop_cnt  <= 1'b0;
            surp_cnt  <= '0;
        end
        else
        begin
            state <= next_state;

            if (state == anim_pkg::Walk4)
                walk_lap <= (walk_lap == LAP_LAST) ? '0 : walk_lap + 1'b1;
            else if (state == anim_pkg::Hidden)
                walk_lap <= '0;

            // three Sniff1/Sniff2 pairs make one stop
            if (state == anim_pkg::Sniff2)
            begin
                if (stop_done)
                begin
                    sniff_cnt <= '0;
                    stop_cnt  <= ~stop_cnt;
                end
                else
                    sniff_cnt <= sniff_cnt + 1'b1;
            end

            if (state == anim_pkg::Surprised)
                surp_cnt <= (surp_cnt == SURP_LAST) ? '0 : surp_cnt + 1'b1;

            // arc step restarts at zero for the fall half
            if (state == anim_pkg::JumpRise || state == anim_pkg::JumpFall)
                arc_idx <= (arc_idx == ARC_LAST) ? '0 : arc_idx + 1'b1;
        end
    end

    assign pose.state    = state;
    assign pose.walk_lap = walk_lap;
    assign pose.arc_idx  = arc_idx;

endmodule

`default_nettype wire

// File: source/jump_arc_rom.sv
`default_nettype none

module jump_arc_rom (
    input  wire                     falling,
    input  wire anim_pkg::arc_idx_t arc_idx,
    output scene_pkg::coord_t       arc_x,
    output scene_pkg::coord_t       arc_y
);

    localparam int LAST = anim_pkg::ARC_STEPS - 1;

    // rising half, lift-off to apex
    localparam scene_pkg::coord_t RISE_X [anim_pkg::ARC_STEPS] = '{
        10'd267, 10'd276, 10'd285, 10'd294, 10'd303,
        10'd312, 10'd321, 10'd330, 10'd341, 10'd352
    };
    localparam scene_pkg::coord_t RISE_Y [anim_pkg::ARC_STEPS] = '{
        10'd290, 10'd274, 10'd260, 10'd248, 10'd238,
        10'd229, 10'd222, 10'd217, 10'd213, 10'd212
    };

    // falling half, apex down to the grass line
    localparam scene_pkg::coord_t FALL_X [anim_pkg::ARC_STEPS] = '{
        10'd352, 10'd363, 10'd374, 10'd383, 10'd392,
        10'd401, 10'd410, 10'd419, 10'd428, 10'd437
    };
    localparam scene_pkg::coord_t FALL_Y [anim_pkg::ARC_STEPS] = '{
        10'd212, 10'd213, 10'd217, 10'd222, 10'd229,
        10'd238, 10'd248, 10'd260, 10'd274, 10'd290
    };

    int idx;

    always_comb
    begin
        // steps past the table hold the last point
        idx = (int'(arc_idx) > LAST) ? LAST : int'(arc_idx);
        if (falling)
        begin
            arc_x = FALL_X[idx];
            arc_y = FALL_Y[idx];
        end
        else
        begin
            arc_x = RISE_X[idx];
            arc_y = RISE_Y[idx];
        end
    end

endmodule

`default_nettype wire

// File: source/scene_pkg.sv
`default_nettype none

package scene_pkg;

    localparam int COORD_W = 10;

    // screen coordinate, x or y
    typedef logic [COORD_W-1:0] coord_t;

    // row the dog walks on
    localparam coord_t GROUND_Y = 10'd290;

    // row where the dog sits out of sight behind the grass
    localparam coord_t HIDDEN_Y = 10'd318;

    // power-up start column and pixels per full lap
    localparam coord_t DEFAULT_START_X = 10'd11;
    localparam coord_t DEFAULT_STEP_X  = 10'd32;

    // laps after which the dog stops to sniff
    localparam logic [3:0] DEFAULT_SNIFF_A = 4'd4;
    localparam logic [3:0] DEFAULT_SNIFF_B = 4'd7;

    // column offset added by each walk pose within a lap
    localparam coord_t STRIDE_X = 10'd8;

endpackage

`default_nettype wire

// File: sources.f
source/anim_pkg.sv
source/scene_pkg.sv
source/dog_pose_if.sv
source/dog_config.sv
source/dog_sequencer.sv
source/jump_arc_rom.sv
source/dog_position.sv
source/dog_anim_top.sv
bench/dog_anim_chk.sv
bench/dog_anim_tb.sv
